//--- include/sha_consts.svh
// SHA accelerator constants
`ifndef SHA_CONSTS_SVH
`define SHA_CONSTS_SVH

////////////////////
// CSR word addresses
`define SHA_CSR_CTRL_ADDR   4'd1
`define SHA_CSR_DATA_ADDR   4'd2
`define SHA_CSR_LEN_ADDR    4'd3

// Address bit 3 set selects a digest word, low bits pick the word
`define SHA_CSR_DIGEST_BIT  3

////////////////////
// Control and status bit positions
`define SHA_CTRL_START_BIT  4
`define SHA_STAT_DONE_BIT   5

// Length must be a whole number of 64-byte blocks
`define SHA_LEN_MASK        32'hffff_ffc0

////////////////////
// Block geometry and round count
`define SHA_BLOCK_WORDS     16
`define SHA_ROUNDS          64

`endif

//--- hdl/sha_pkg.sv
// SHA accelerator shared types
package sha_pkg;

    // One CSR bus request from the host
    typedef struct packed {
        logic        read;
        logic        write;
        logic [3:0]  address;
        logic [31:0] writedata;
    } csr_req_t;

    // Decoded commands from CSR unit to block assembler
    typedef struct packed {
        logic        start;
        logic        data_valid;
        logic [31:0] data;
        logic [31:0] length;
    } sha_cmd_t;

    // Block handed to the compression core, word 0 in bits 511:480
    typedef struct packed {
        logic         valid;
        logic         first;
        logic [511:0] data;
    } sha_block_t;

    // Digest with H0 in bits 31:0 and H7 in bits 255:224
    typedef logic [255:0] sha_digest_t;

    // Assembler FSM states
    typedef enum logic [2:0] {IDLE, ACCEPT, PAD, WAIT, DONE} asm_state_t;

    // Bus words are little-endian, SHA words big-endian
    function automatic logic [31:0] bswap32(input logic [31:0] x);
        bswap32 = {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction

endpackage

//--- hdl/csr_regs.sv
// SHA CSR register block
`include "sha_consts.svh"

module csr_regs
    import sha_pkg::*;
(
    input  logic        clk,
    input  logic        areset,
    input  csr_req_t    csr,
    input  logic        data_ready,
    input  logic        done_flag,
    input  sha_digest_t digest,
    output sha_cmd_t    cmd,
    output logic [31:0] csr_readdata,
    output logic        csr_waitrequest
);

    logic        wr_ctrl;
    logic        wr_data;
    logic        wr_len;
    logic [31:0] len_q;
    logic        done_status;
    logic [31:0] status_word;
    logic [31:0] digest_word;

    ////////////////////
    // Write decode, full four-bit address compare
    assign wr_ctrl = csr.write && (csr.address == `SHA_CSR_CTRL_ADDR);
    assign wr_data = csr.write && (csr.address == `SHA_CSR_DATA_ADDR);
    assign wr_len  = csr.write && (csr.address == `SHA_CSR_LEN_ADDR);

    // Start pulse when the start bit is written
    assign cmd.start      = wr_ctrl && csr.writedata[`SHA_CTRL_START_BIT];
    // Data word only passes when the assembler can take it
    assign cmd.data_valid = wr_data && data_ready;
    assign cmd.data       = csr.writedata;
    assign cmd.length     = len_q;

    // Length register, low six bits forced to zero
    always_ff @(posedge clk or posedge areset)
    begin
        if (areset)
            len_q <= '0;
        else if (wr_len)
            len_q <= csr.writedata & `SHA_LEN_MASK;
    end

    // Registered done status
    // A start write clears it right away, before the assembler leaves DONE
    always_ff @(posedge clk or posedge areset)
    begin
        if (areset)
            done_status <= 1'b0;
        else
            done_status <= done_flag && !cmd.start;
    end

    ////////////////////
    // Read path
    always_comb
    begin
        status_word = '0;
        status_word[`SHA_STAT_DONE_BIT] = done_status;
    end

    // Digest word back to little-endian for the host
    assign digest_word = bswap32(digest[32*csr.address[2:0] +: 32]);

    // Any address with bit 3 clear reads status
    always_comb
    begin
        if (!csr.read)
            csr_readdata = '0;
        else if (csr.address[`SHA_CSR_DIGEST_BIT])
            csr_readdata = digest_word;
        else
            csr_readdata = status_word;
    end

    // Stall during reset and on data writes the assembler cannot accept
    assign csr_waitrequest = areset || (wr_data && !data_ready);

endmodule

//--- hdl/block_assembler.sv
// SHA block assembler
`include "sha_consts.svh"

module block_assembler
    import sha_pkg::*;
(
    input  logic       clk,
    input  logic       areset,
    input  sha_cmd_t   cmd,
    input  logic       digest_valid,
    output sha_block_t blk,
    output logic       data_ready,
    output logic       done_flag
);

    asm_state_t   state;
    logic [3:0]   slice;
    logic [31:0]  remaining;
    logic         first_next;
    logic         pending;
    logic         blk_valid;
    logic         blk_first;
    logic [511:0] blk_data;
    logic         word_go;
    logic         pad_go;
    logic         block_full;

    // Word that completes the current block
    assign block_full = (slice == 4'(`SHA_BLOCK_WORDS - 1));

    // Hold off the last word of a block until the core is free
    assign data_ready = (state == ACCEPT) && !(block_full && pending);
    assign done_flag  = (state == DONE);

    assign word_go = (state == ACCEPT) && cmd.data_valid;
    // Padding block leaves once nothing is pending
    assign pad_go  = (state == PAD) && !pending;

    ////////////////////
    // Control FSM
    always_ff @(posedge clk or posedge areset)
    begin
        if (areset)
        begin
            state      <= IDLE;
            slice      <= '0;
            remaining  <= '0;
            first_next <= 1'b0;
            pending    <= 1'b0;
            blk_valid  <= 1'b0;
            blk_first  <= 1'b0;
        end
        else
        begin
            blk_valid <= 1'b0;
            // Core finished, a new issue below takes priority
            if (digest_valid)
                pending <= 1'b0;

            case (state)
                IDLE, DONE:
                begin
                    if (cmd.start)
                    begin
                        remaining  <= cmd.length;
                        slice      <= '0;
                        // Next block starts from the initial hash values
                        first_next <= 1'b1;
                        state      <= (cmd.length == '0) ? PAD : ACCEPT;
                    end
                end
                ACCEPT:
                begin
                    if (word_go)
                    begin
                        // Wraps to 0 after the sixteenth word
                        slice     <= slice + 4'd1;
                        remaining <= remaining - 32'd4;
                        if (block_full)
                        begin
                            blk_valid  <= 1'b1;
                            blk_first  <= first_next;
                            first_next <= 1'b0;
                            pending    <= 1'b1;
                        end
                        if (remaining == 32'd4)
                            state <= PAD;
                    end
                end
                PAD:
                begin
                    if (pad_go)
                    begin
                        blk_valid  <= 1'b1;
                        blk_first  <= first_next;
                        first_next <= 1'b0;
                        pending    <= 1'b1;
                        state      <= WAIT;
                    end
                end
                WAIT:
                begin
                    // Only the padding block is in flight here
                    if (digest_valid)
                        state <= DONE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // Block payload
    always_ff @(posedge clk)
    begin
        if (word_go)
            blk_data[32*(4'd15 - slice) +: 32] <= bswap32(cmd.data);
        else if (pad_go)
            // Leading one, zero fill, message length in bits
            blk_data <= {1'b1, 447'b0, 29'b0, cmd.length, 3'b0};
    end

    assign blk = '{valid: blk_valid, first: blk_first, data: blk_data};

    // The CSR unit must never pass a word the assembler refused
    a_strobe_when_ready: assert property (@(posedge clk) disable iff (areset)
        cmd.data_valid |-> data_ready)
        else $error("data strobe while data_ready is low");

endmodule

//--- hdl/sha256_core.sv
// SHA-256 compression core
`include "sha_consts.svh"

module sha256_core
    import sha_pkg::*;
(
    input  logic        clk,
    input  logic        areset,
    input  sha_block_t  blk,
    output logic        digest_valid,
    output sha_digest_t digest
);

    ////////////////////
    // Round constants
    localparam logic [31:0] K [0:`SHA_ROUNDS-1] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Initial hash values, H0 in the lowest word
    localparam logic [7:0][31:0] IV = {
        32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
        32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
    };

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        rotr = (x >> n) | (x << (32 - n));
    endfunction

    logic [7:0][31:0]  hv;
    logic [7:0][31:0]  wv;
    logic [15:0][31:0] w;
    logic [5:0]        round;
    logic              running;
    logic              finish;
    logic              first_q;
    logic [31:0]       t1;
    logic [31:0]       t2;
    logic [31:0]       w_next;

    // Round function, wv[0] is a and wv[7] is h
    always_comb
    begin
        t1 = wv[7] + (rotr(wv[4], 6) ^ rotr(wv[4], 11) ^ rotr(wv[4], 25))
            + ((wv[4] & wv[5]) ^ (~wv[4] & wv[6])) + K[round] + w[0];
        t2 = (rotr(wv[0], 2) ^ rotr(wv[0], 13) ^ rotr(wv[0], 22))
            + ((wv[0] & wv[1]) ^ (wv[0] & wv[2]) ^ (wv[1] & wv[2]));
        // Schedule word sixteen ahead of w[0]
        w_next = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9]
            + (rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
    end

    ////////////////////
    // Sequencing: load, 64 rounds, then one add cycle
    always_ff @(posedge clk or posedge areset)
    begin
        if (areset)
        begin
            running      <= 1'b0;
            finish       <= 1'b0;
            round        <= '0;
            digest_valid <= 1'b0;
        end
        else
        begin
            digest_valid <= finish;
            finish       <= 1'b0;
            if (blk.valid)
            begin
                running <= 1'b1;
                round   <= '0;
            end
            else if (running)
            begin
                round <= round + 6'd1;
                if (round == 6'(`SHA_ROUNDS - 1))
                begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    // Working variables, schedule window and chaining state
    always_ff @(posedge clk)
    begin
        if (blk.valid)
        begin
            wv      <= blk.first ? IV : hv;
            first_q <= blk.first;
            for (int i = 0; i < `SHA_BLOCK_WORDS; i++)
                w[i] <= blk.data[32*(15 - i) +: 32];
        end
        else if (running)
        begin
            wv <= {wv[6], wv[5], wv[4], wv[3] + t1, wv[2], wv[1], wv[0], t1 + t2};
            w  <= {w_next, w[15:1]};
        end
        // Chain only moves at block end, so digest holds in between
        if (finish)
            for (int i = 0; i < 8; i++)
                hv[i] <= (first_q ? IV[i] : hv[i]) + wv[i];
    end

    assign digest = hv;

    // Assembler must wait for the previous digest before the next block
    a_no_block_while_busy: assert property (@(posedge clk) disable iff (areset)
        blk.valid |-> !running && !finish)
        else $error("block valid while rounds are running");

endmodule

//--- hdl/sha_accel_top.sv
// SHA-256 accelerator top
module sha_accel_top
    import sha_pkg::*;
(
    input  logic        clk,
    input  logic        areset,
    input  csr_req_t    csr,
    output logic [31:0] csr_readdata,
    output logic        csr_waitrequest
);

    sha_cmd_t    cmd;
    sha_block_t  blk;
    sha_digest_t digest;
    logic        data_ready;
    logic        done_flag;
    logic        digest_valid;

    ////////////////////
    // Host bus decode and read mux
    csr_regs u_csr (
        .clk             (clk),
        .areset          (areset),
        .csr             (csr),
        .data_ready      (data_ready),
        .done_flag       (done_flag),
        .digest          (digest),
        .cmd             (cmd),
        .csr_readdata    (csr_readdata),
        .csr_waitrequest (csr_waitrequest)
    );

    // Words in, 512-bit blocks out
    block_assembler u_asm (
        .clk          (clk),
        .areset       (areset),
        .cmd          (cmd),
        .digest_valid (digest_valid),
        .blk          (blk),
        .data_ready   (data_ready),
        .done_flag    (done_flag)
    );

    // One round per clock
    sha256_core u_core (
        .clk          (clk),
        .areset       (areset),
        .blk          (blk),
        .digest_valid (digest_valid),
        .digest       (digest)
    );

endmodule

//--- tb/tb_sha_accel.sv
// SHA accelerator testbench
`include "sha_consts.svh"

module tb_sha_accel
    import sha_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    // Sample point, a quarter period after the falling edge
    localparam int SAMPLE_DELAY = 10;
    // Blocks hashed per test, padding block included
    localparam int TEST_BLOCKS [5] = '{0, 2, 4, 3, 3};

    localparam logic [31:0] ROUND_K [0:63] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    logic        clk;
    logic        areset;
    csr_req_t    csr;
    logic [31:0] csr_readdata;
    logic        csr_waitrequest;

    logic [31:0] lfsr_state;
    logic [7:0]  msg_bytes [0:191];
    int          check_count;
    int          error_count;

    // Pending checks, filled by the tests and drained by the compare process
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       cmp_name;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;

    sha_accel_top dut (
        .clk             (clk),
        .areset          (areset),
        .csr             (csr),
        .csr_readdata    (csr_readdata),
        .csr_waitrequest (csr_waitrequest)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Random words and SHA-256 model
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Galois form, taps for x^32 + x^22 + x^2 + x + 1
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] word);
        word = '0;
        for (int b = 0; b < 32; b++)
        begin
            word       = {lfsr_state[0], word[31:1]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
        logic [63:0] doubled;
        doubled      = {x, x} >> n;
        rotate_right = doubled[31:0];
    endfunction

    // Digest bytes of msg_bytes[0 .. nbytes-1] in standard output order
    function automatic logic [0:31][7:0] sha256_ref(input int nbytes);
        logic [7:0]       pad [0:319];
        logic [31:0]      h [0:7];
        logic [31:0]      v [0:7];
        logic [31:0]      w [0:63];
        logic [31:0]      t1;
        logic [31:0]      t2;
        logic [63:0]      bit_len;
        logic [0:31][7:0] out;
        int               total;
        h = '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
              32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
        // Standard padding, 0x80 then zeros then the 64-bit bit count
        total = ((nbytes + 8) / 64 + 1) * 64;
        for (int i = 0; i < total; i++)
            pad[i] = (i < nbytes) ? msg_bytes[i] : 8'h00;
        pad[nbytes] = 8'h80;
        bit_len = 64'(nbytes) * 8;
        for (int i = 0; i < 8; i++)
            pad[total - 1 - i] = bit_len[8*i +: 8];
        for (int blk_i = 0; blk_i < total / 64; blk_i++)
        begin
            for (int t = 0; t < 64; t++)
            begin
                if (t < 16)
                    w[t] = {pad[64*blk_i + 4*t], pad[64*blk_i + 4*t + 1],
                            pad[64*blk_i + 4*t + 2], pad[64*blk_i + 4*t + 3]};
                else
                    w[t] = (rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19)
                            ^ (w[t-2] >> 10)) + w[t-7] + (rotate_right(w[t-15], 7)
                            ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3)) + w[t-16];
            end
            v = h;
            for (int t = 0; t < 64; t++)
            begin
                t1 = v[7] + (rotate_right(v[4], 6) ^ rotate_right(v[4], 11)
                     ^ rotate_right(v[4], 25)) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
                     + ROUND_K[t] + w[t];
                t2 = (rotate_right(v[0], 2) ^ rotate_right(v[0], 13)
                     ^ rotate_right(v[0], 22)) + ((v[0] & v[1]) ^ (v[0] & v[2])
                     ^ (v[1] & v[2]));
                for (int i = 7; i > 0; i--)
                    v[i] = v[i-1];
                // e takes d plus t1, a takes t1 plus t2
                v[4] = v[4] + t1;
                v[0] = t1 + t2;
            end
            for (int i = 0; i < 8; i++)
                h[i] = h[i] + v[i];
        end
        for (int i = 0; i < 8; i++)
            for (int j = 0; j < 4; j++)
                out[4*i + j] = h[i][31 - 8*j -: 8];
        sha256_ref = out;
    endfunction

    ////////////////////
    // Bus tasks, each starts and ends on a falling edge
    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        // Fields are read, write, address, writedata
        csr = {1'b0, 1'b1, addr, data};
        #(SAMPLE_DELAY);
        // Hold the request until the DUT takes it
        while (csr_waitrequest)
        begin
            @(negedge clk);
            #(SAMPLE_DELAY);
        end
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        csr = {1'b1, 1'b0, addr, 32'd0};
        #(SAMPLE_DELAY);
        data = csr_readdata;
        @(negedge clk);
    endtask

    task automatic poll_done(output logic [31:0] status);
        status = '0;
        while (!status[`SHA_STAT_DONE_BIT])
            bus_read(`SHA_CSR_CTRL_ADDR, status);
        csr = '0;
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // Waits one edge so the compare process has drained the queue
    task automatic end_test(input string name, input int start_errors);
        @(posedge clk);
        @(negedge clk);
        if (error_count == start_errors)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d mismatches", name, error_count - start_errors);
    endtask

    ////////////////////
    // One full hash, length written as given, nbytes of random data streamed
    task automatic run_hash(input string name, input logic [31:0] len_write,
                            input int nbytes);
        logic [31:0]      word;
        logic [31:0]      status;
        logic [0:31][7:0] ref_dig;
        int               start_errors;
        start_errors = error_count;
        for (int j = 0; j < nbytes / 4; j++)
        begin
            random_word(word);
            // Bus word is little-endian, byte 0 in bits 7:0
            for (int b = 0; b < 4; b++)
                msg_bytes[4*j + b] = word[8*b +: 8];
        end
        ref_dig = sha256_ref(nbytes);

        bus_write(`SHA_CSR_LEN_ADDR, len_write);
        bus_write(`SHA_CSR_CTRL_ADDR, 32'd1 << `SHA_CTRL_START_BIT);
        bus_read(`SHA_CSR_CTRL_ADDR, status);
        expect_value("csr_readdata (status after start)", 32'd0, status);
        // Back to back, stalls come from waitrequest
        for (int j = 0; j < nbytes / 4; j++)
            bus_write(`SHA_CSR_DATA_ADDR, {msg_bytes[4*j + 3], msg_bytes[4*j + 2],
                                           msg_bytes[4*j + 1], msg_bytes[4*j]});
        csr = '0;

        poll_done(status);
        expect_value("csr_readdata (status)", 32'd1 << `SHA_STAT_DONE_BIT, status);
        for (int i = 0; i < 8; i++)
        begin
            bus_read(4'(8 + i), word);
            expect_value($sformatf("csr_readdata (digest word %0d)", i),
                         {ref_dig[4*i + 3], ref_dig[4*i + 2], ref_dig[4*i + 1],
                          ref_dig[4*i]}, word);
        end
        csr = '0;
        end_test(name, start_errors);
    endtask

    ////////////////////
    // Compare process
    always @(posedge clk)
    begin
        while (exp_q.size() > 0)
        begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            check_count++;
            if (cmp_exp !== cmp_act)
            begin
                error_count++;
                $display("[ERROR] %0d ns %s expected %08h actual %08h",
                         $time, cmp_name, cmp_exp, cmp_act);
            end
        end
    end

    // Watchdog sized from the block count of every test
    initial
    begin
        longint limit_ns;
        limit_ns = 0;
        for (int t = 0; t < 5; t++)
            limit_ns += (TEST_BLOCKS[t] * 90 + 200) * CLK_PERIOD;
        limit_ns *= 2;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, a test never finished", limit_ns);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////
    // Test sequence
    initial
    begin
        logic [31:0] status;
        int          start_errors;
        clk         = 1'b0;
        areset      = 1'b1;
        csr         = '0;
        lfsr_state  = 32'h861d;
        check_count = 0;
        error_count = 0;
        repeat (3) @(negedge clk);
        areset = 1'b0;

        // Idle state right after reset
        start_errors = error_count;
        bus_read(`SHA_CSR_CTRL_ADDR, status);
        expect_value("csr_readdata (status)", 32'd0, status);
        csr = '0;
        #(SAMPLE_DELAY);
        expect_value("csr_waitrequest", 32'd0, {31'd0, csr_waitrequest});
        @(negedge clk);
        end_test("reset", start_errors);

        run_hash("hash_64", 32'd64, 64);
        // Second and third block stall on the busy core
        run_hash("hash_192", 32'd192, 192);
        // Starts from DONE, chain must restart from the initial values
        run_hash("restart_128", 32'd128, 128);
        // Low six bits of the length are dropped
        run_hash("len_130", 32'd130, 128);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hdl/sha_pkg.sv
hdl/csr_regs.sv
hdl/block_assembler.sv
hdl/sha256_core.sv
hdl/sha_accel_top.sv
tb/tb_sha_accel.sv
